//--- verification/decode_golden.txt
# ctl(fs_valid,es_allowin,flush) pc inst es(valid,load,wen) addr data ms(valid,wen) addr data wb_we addr data
# then st(chk,allowin,issue_valid,br_taken) op en(dest,v1,v2,v3) dest v1 v2 v3 target
2 0 0 0 0 0 0 0 0 1 01 11111111 4 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 1 02 22222222 4 0 0 0 0 0 0 0
6 00400000 00222021 0 0 0 0 0 0 1 03 80000003 4 0 0 0 0 0 0 0
6 00400004 00222823 0 0 0 0 0 0 0 0 0 e 01 e 04 11111111 22222222 0 00400004
6 00400008 00223024 0 0 0 0 0 0 0 0 0 e 02 e 05 11111111 22222222 0 00400008
6 0040000c 00223825 0 0 0 0 0 0 0 0 0 e 03 e 06 11111111 22222222 0 0040000c
6 00400010 00224026 0 0 0 0 0 0 0 0 0 e 04 e 07 11111111 22222222 0 00400010
6 00400014 00224827 0 0 0 0 0 0 0 0 0 e 05 e 08 11111111 22222222 0 00400014
6 00400018 0061502a 0 0 0 0 0 0 0 0 0 e 06 e 09 11111111 22222222 0 00400018
6 0040001c 0061582b 0 0 0 0 0 0 0 0 0 e 07 e 0a 80000003 11111111 0 0040001c
6 00400020 00026100 0 0 0 0 0 0 0 0 0 e 08 e 0b 80000003 11111111 0 00400020
6 00400024 00036a02 0 0 0 0 0 0 0 0 0 e 09 e 0c 22222222 4 0 00400024
6 00400028 000377c3 0 0 0 0 0 0 0 0 0 e 0a e 0d 80000003 8 0 00400028
6 0040002c 242ffffc 0 0 0 0 0 0 0 0 0 e 0b e 0e 80000003 1f 0 0040002c
6 00400030 28508000 0 0 0 0 0 0 0 0 0 e 0c e 0f 11111111 fffffffc 0 00400030
6 00400034 2c717fff 0 0 0 0 0 0 0 0 0 e 10 e 10 22222222 ffff8000 0 00400034
6 00400038 3032ff00 0 0 0 0 0 0 0 0 0 e 11 e 11 80000003 7fff 0 00400038
6 0040003c 34538001 0 0 0 0 0 0 0 0 0 e 0d e 12 11111111 ff00 0 0040003c
6 00400040 3874abcd 0 0 0 0 0 0 0 0 0 e 0e e 13 22222222 8001 0 00400040
6 00400044 3c151234 0 0 0 0 0 0 0 0 0 e 0f e 14 80000003 abcd 0 00400044
6 00400048 8c360010 0 0 0 0 0 0 0 0 0 e 12 c 15 12340000 0 0 00400048
6 0040004c ac22fff8 0 0 0 0 0 0 0 0 0 e 13 e 16 11111111 10 0 0040004c
6 00400050 0022b821 0 0 0 0 0 0 0 0 0 e 14 7 00 11111111 fffffff8 22222222 00400050
6 00400054 0022c021 5 01 aaaaaaaa 3 01 bbbbbbbb 1 02 cccccccc e 01 e 17 aaaaaaaa cccccccc 0 00400054
6 00400058 0002c821 1 01 dddddddd 3 02 bbbbbbbb 1 02 eeeeeeee e 01 e 18 11111111 bbbbbbbb 0 00400058
6 0040005c 0022d021 5 00 99999999 3 00 88888888 1 00 77777777 e 01 e 19 0 eeeeeeee 0 0040005c
6 00400060 10210003 7 01 0 0 0 0 0 0 0 8 01 e 1a 0 eeeeeeee 0 00400060
6 00400060 10210003 7 01 0 0 0 0 0 0 0 8 01 e 1a 0 eeeeeeee 0 00400060
6 00400060 10210003 5 01 13579bdf 0 0 0 0 0 0 e 01 e 1a 13579bdf eeeeeeee 0 00400060
6 00400070 1022fffc 0 0 0 0 0 0 0 0 0 f 15 7 00 11111111 11111111 c 00400070
6 00400074 14220010 0 0 0 0 0 0 0 0 0 e 15 7 00 11111111 eeeeeeee fffffff0 00400064
6 004000b8 14630001 0 0 0 0 0 0 0 0 0 f 16 7 00 11111111 eeeeeeee 40 004000b8
6 004000bc 08100040 0 0 0 0 0 0 0 0 0 e 16 7 00 80000003 80000003 4 004000c0
6 9ffffffc 0c000200 0 0 0 0 0 0 0 0 0 f 17 1 00 0 0 00100040 00400100
6 a0000800 00600008 0 0 0 0 0 0 0 0 0 f 18 9 1f 0 0 200 a0000800
6 00400200 34245a5a 0 0 0 3 03 00400200 0 0 0 f 19 1 00 0 0 00400200 00400200
4 00400204 24450001 0 0 0 0 0 0 0 0 0 a 0e e 04 11111111 5a5a 0 00400204
4 00400204 24450001 0 0 0 0 0 0 0 0 0 a 0e e 04 11111111 5a5a 0 00400204
6 00400204 24450001 0 0 0 0 0 0 0 0 0 e 0e e 04 11111111 5a5a 0 00400204
7 00400300 fc000000 0 0 0 0 0 0 0 0 0 e 0c e 05 eeeeeeee 1 0 00400208
6 00400300 fc000000 0 0 0 0 0 0 0 0 0 4 0 0 0 0 0 0 0
6 00400304 0022203f 0 0 0 0 0 0 0 0 0 e 00 0 00 0 0 0 00400304
2 0 0 0 0 0 0 0 0 0 0 0 e 00 0 00 0 0 0 00400308
2 0 0 0 0 0 0 0 0 0 0 0 4 0 0 0 0 0 0 0

//--- src.f
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/branch_resolve.sv
logic/stage_control.sv
logic/decode_stage.sv
verification/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module decode_stage_tb -f src.f -o sim_decode_stage &&
./obj_dir/sim_decode_stage || {
  echo "simulation failed"
  exit 1
}

//--- verification/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;
  import decode_pkg::*;

  localparam int CLOCK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int OPEN_TRIES   = 4;
  localparam int MAX_READS    = 200;

  logic            clock;
  logic            reset;
  logic            fs_valid;
  logic [XLEN-1:0] fs_pc;
  logic [XLEN-1:0] fs_inst;
  logic            ds_allowin;
  logic            es_allowin;
  logic            issue_valid;
  op_e             issue_op;
  logic            issue_dest_en;
  reg_addr_t       issue_dest;
  logic            issue_v1_en;
  logic [XLEN-1:0] issue_v1;
  logic            issue_v2_en;
  logic [XLEN-1:0] issue_v2;
  logic            issue_v3_en;
  logic [XLEN-1:0] issue_v3;
  logic            es_valid;
  logic            es_load;
  logic            es_wen;
  reg_addr_t       es_waddr;
  logic [XLEN-1:0] es_wdata;
  logic            ms_valid;
  logic            ms_wen;
  reg_addr_t       ms_waddr;
  logic [XLEN-1:0] ms_wdata;
  logic            wb_we;
  reg_addr_t       wb_waddr;
  logic [XLEN-1:0] wb_wdata;
  logic            flush;
  logic            br_taken;
  logic [XLEN-1:0] br_target;

  // stimulus then expected values of one golden line
  logic [31:0] in_ctl, pc_f, inst_f, es_ctl, es_addr, es_data, ms_ctl, ms_addr, ms_data;
  logic [31:0] wb_ctl, wb_addr, wb_data, exp_st, exp_op, exp_en, exp_dest;
  logic [31:0] exp_v1, exp_v2, exp_v3, exp_target;

  int    fd;
  int    line_count;
  int    error_count;
  string line;

  decode_stage #(
    .REG_COUNT (32)
  ) decode_stage_i (
    .clock           (clock),
    .reset           (reset),
    .fs_valid_i      (fs_valid),
    .fs_pc_i         (fs_pc),
    .fs_inst_i       (fs_inst),
    .ds_allowin_o    (ds_allowin),
    .es_allowin_i    (es_allowin),
    .issue_valid_o   (issue_valid),
    .issue_op_o      (issue_op),
    .issue_dest_en_o (issue_dest_en),
    .issue_dest_o    (issue_dest),
    .issue_v1_en_o   (issue_v1_en),
    .issue_v1_o      (issue_v1),
    .issue_v2_en_o   (issue_v2_en),
    .issue_v2_o      (issue_v2),
    .issue_v3_en_o   (issue_v3_en),
    .issue_v3_o      (issue_v3),
    .es_valid_i      (es_valid),
    .es_load_i       (es_load),
    .es_wen_i        (es_wen),
    .es_waddr_i      (es_waddr),
    .es_wdata_i      (es_wdata),
    .ms_valid_i      (ms_valid),
    .ms_wen_i        (ms_wen),
    .ms_waddr_i      (ms_waddr),
    .ms_wdata_i      (ms_wdata),
    .wb_we_i         (wb_we),
    .wb_waddr_i      (wb_waddr),
    .wb_wdata_i      (wb_wdata),
    .flush_i         (flush),
    .br_taken_o      (br_taken),
    .br_target_o     (br_target)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    assert (got == want) else begin
      error_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("Done: errors found");
      $fatal(1, "output mismatch on %s", what);
    end
  endtask

  task automatic apply_stimulus();
    fs_valid   = in_ctl[2];
    es_allowin = in_ctl[1];
    flush      = in_ctl[0];
    fs_pc      = pc_f;
    fs_inst    = inst_f;
    es_valid   = es_ctl[2];
    es_load    = es_ctl[1];
    es_wen     = es_ctl[0];
    es_waddr   = es_addr[4:0];
    es_wdata   = es_data;
    ms_valid   = ms_ctl[1];
    ms_wen     = ms_ctl[0];
    ms_waddr   = ms_addr[4:0];
    ms_wdata   = ms_data;
    wb_we      = wb_ctl[0];
    wb_waddr   = wb_addr[4:0];
    wb_wdata   = wb_data;
  endtask

  task automatic check_outputs();
    expect_equal("ds_allowin_o", 32'(ds_allowin), 32'(exp_st[2]));
    expect_equal("issue_valid_o", 32'(issue_valid), 32'(exp_st[1]));
    expect_equal("br_taken_o", 32'(br_taken), 32'(exp_st[0]));
    // operand fields only mean something while the stage holds an instruction
    if (exp_st[3]) begin
      expect_equal("issue_op_o", 32'(issue_op), exp_op);
      expect_equal("issue_dest_en_o", 32'(issue_dest_en), 32'(exp_en[3]));
      expect_equal("issue_v1_en_o", 32'(issue_v1_en), 32'(exp_en[2]));
      expect_equal("issue_v2_en_o", 32'(issue_v2_en), 32'(exp_en[1]));
      expect_equal("issue_v3_en_o", 32'(issue_v3_en), 32'(exp_en[0]));
      expect_equal("issue_dest_o", 32'(issue_dest), exp_dest);
      expect_equal("issue_v1_o", issue_v1, exp_v1);
      expect_equal("issue_v2_o", issue_v2, exp_v2);
      expect_equal("issue_v3_o", issue_v3, exp_v3);
      expect_equal("br_target_o", br_target, exp_target);
    end
  endtask

  initial begin
    int tries;
    int reads;
    int code;
    int fields;
    reset       = 1'b1;
    in_ctl      = '0;
    {pc_f, inst_f, es_ctl, es_addr, es_data, ms_ctl, ms_addr, ms_data} = '0;
    {wb_ctl, wb_addr, wb_data} = '0;
    apply_stimulus();
    error_count = 0;
    line_count  = 0;
    fd          = 0;
    tries       = 0;
    while (fd == 0 && tries < OPEN_TRIES) begin
      fd = $fopen("verification/decode_golden.txt", "r");
      tries++;
      if (fd == 0) begin
        @(posedge clock);
      end
    end
    if (fd == 0) begin
      $display("Done: errors found");
      $fatal(1, "could not open verification/decode_golden.txt");
    end
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    reads = 0;
    while (!$feof(fd) && reads < MAX_READS) begin
      code = $fgets(line, fd);
      reads++;
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          in_ctl, pc_f, inst_f, es_ctl, es_addr, es_data, ms_ctl, ms_addr, ms_data,
          wb_ctl, wb_addr, wb_data, exp_st, exp_op, exp_en, exp_dest,
          exp_v1, exp_v2, exp_v3, exp_target);
        if (fields != 20) begin
          $display("Done: errors found");
          $fatal(1, "golden line %0d has %0d fields instead of 20", line_count + 1, fields);
        end
        @(negedge clock);
        apply_stimulus();
        // sample just ahead of the next rising edge
        #(CLOCK_PERIOD / 2 - 1);
        check_outputs();
        line_count++;
      end
    end
    if (!$feof(fd)) begin
      $display("Done: errors found");
      $fatal(1, "timed out reading the golden file after %0d reads", reads);
    end
    $fclose(fd);
    if (error_count == 0 && line_count > 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "no golden lines were checked");
    end
  end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage #(
  parameter int REG_COUNT = 32
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        fs_valid_i,
  input  logic [decode_pkg::XLEN-1:0] fs_pc_i,
  input  logic [decode_pkg::XLEN-1:0] fs_inst_i,
  output logic                        ds_allowin_o,
  input  logic                        es_allowin_i,
  output logic                        issue_valid_o,
  output decode_pkg::op_e             issue_op_o,
  output logic                        issue_dest_en_o,
  output decode_pkg::reg_addr_t       issue_dest_o,
  output logic                        issue_v1_en_o,
  output logic [decode_pkg::XLEN-1:0] issue_v1_o,
  output logic                        issue_v2_en_o,
  output logic [decode_pkg::XLEN-1:0] issue_v2_o,
  output logic                        issue_v3_en_o,
  output logic [decode_pkg::XLEN-1:0] issue_v3_o,
  input  logic                        es_valid_i,
  input  logic                        es_load_i,
  input  logic                        es_wen_i,
  input  decode_pkg::reg_addr_t       es_waddr_i,
  input  logic [decode_pkg::XLEN-1:0] es_wdata_i,
  input  logic                        ms_valid_i,
  input  logic                        ms_wen_i,
  input  decode_pkg::reg_addr_t       ms_waddr_i,
  input  logic [decode_pkg::XLEN-1:0] ms_wdata_i,
  input  logic                        wb_we_i,
  input  decode_pkg::reg_addr_t       wb_waddr_i,
  input  logic [decode_pkg::XLEN-1:0] wb_wdata_i,
  input  logic                        flush_i,
  output logic                        br_taken_o,
  output logic [decode_pkg::XLEN-1:0] br_target_o
);
  import decode_pkg::*;

  logic            ds_valid;
  logic [XLEN-1:0] ds_pc;
  logic [XLEN-1:0] ds_inst;
  logic            hazard;
  reg_addr_t       src1_reg;
  reg_addr_t       src2_reg;
  logic            src1_en;
  logic            src2_en;
  imm_kind_e       imm_kind;
  logic            v3_from_rt;
  logic            v3_from_rs;
  logic [XLEN-1:0] rf_rdata0;
  logic [XLEN-1:0] rf_rdata1;

  stage_control stage_control_i (
    .clock         (clock),
    .reset         (reset),
    .fs_valid_i    (fs_valid_i),
    .fs_pc_i       (fs_pc_i),
    .fs_inst_i     (fs_inst_i),
    .flush_i       (flush_i),
    .es_allowin_i  (es_allowin_i),
    .hazard_i      (hazard),
    .ds_allowin_o  (ds_allowin_o),
    .ds_valid_o    (ds_valid),
    .ds_pc_o       (ds_pc),
    .ds_inst_o     (ds_inst),
    .issue_valid_o (issue_valid_o)
  );

  inst_decoder inst_decoder_i (
    .ds_inst_i    (ds_inst),
    .op_o         (issue_op_o),
    .src1_reg_o   (src1_reg),
    .src2_reg_o   (src2_reg),
    .src1_en_o    (src1_en),
    .src2_en_o    (src2_en),
    .imm_kind_o   (imm_kind),
    .v3_from_rt_o (v3_from_rt),
    .v3_from_rs_o (v3_from_rs),
    .dest_en_o    (issue_dest_en_o),
    .dest_o       (issue_dest_o)
  );

  reg_file #(
    .REG_COUNT (REG_COUNT)
  ) reg_file_i (
    .clock    (clock),
    .raddr0_i (src1_reg),
    .raddr1_i (src2_reg),
    .we_i     (wb_we_i),
    .waddr_i  (wb_waddr_i),
    .wdata_i  (wb_wdata_i),
    .rdata0_o (rf_rdata0),
    .rdata1_o (rf_rdata1)
  );

  operand_bypass operand_bypass_i (
    .ds_valid_i   (ds_valid),
    .ds_inst_i    (ds_inst),
    .src1_reg_i   (src1_reg),
    .src2_reg_i   (src2_reg),
    .src1_en_i    (src1_en),
    .src2_en_i    (src2_en),
    .imm_kind_i   (imm_kind),
    .v3_from_rt_i (v3_from_rt),
    .v3_from_rs_i (v3_from_rs),
    .rf_rdata0_i  (rf_rdata0),
    .rf_rdata1_i  (rf_rdata1),
    .es_valid_i   (es_valid_i),
    .es_load_i    (es_load_i),
    .es_wen_i     (es_wen_i),
    .es_waddr_i   (es_waddr_i),
    .es_wdata_i   (es_wdata_i),
    .ms_valid_i   (ms_valid_i),
    .ms_wen_i     (ms_wen_i),
    .ms_waddr_i   (ms_waddr_i),
    .ms_wdata_i   (ms_wdata_i),
    .wb_we_i      (wb_we_i),
    .wb_waddr_i   (wb_waddr_i),
    .wb_wdata_i   (wb_wdata_i),
    .v1_en_o      (issue_v1_en_o),
    .v1_o         (issue_v1_o),
    .v2_en_o      (issue_v2_en_o),
    .v2_o         (issue_v2_o),
    .v3_en_o      (issue_v3_en_o),
    .v3_o         (issue_v3_o),
    .hazard_o     (hazard)
  );

  branch_resolve branch_resolve_i (
    .ds_valid_i  (ds_valid),
    .op_i        (issue_op_o),
    .ds_pc_i     (ds_pc),
    .ds_inst_i   (ds_inst),
    .v1_i        (issue_v1_o),
    .v2_i        (issue_v2_o),
    .v3_i        (issue_v3_o),
    .br_taken_o  (br_taken_o),
    .br_target_o (br_target_o)
  );

endmodule

//--- logic/stage_control.sv
`timescale 1ns/10ps

module stage_control (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        fs_valid_i,
  input  logic [decode_pkg::XLEN-1:0] fs_pc_i,
  input  logic [decode_pkg::XLEN-1:0] fs_inst_i,
  input  logic                        flush_i,
  input  logic                        es_allowin_i,
  input  logic                        hazard_i,
  output logic                        ds_allowin_o,
  output logic                        ds_valid_o,
  output logic [decode_pkg::XLEN-1:0] ds_pc_o,
  output logic [decode_pkg::XLEN-1:0] ds_inst_o,
  output logic                        issue_valid_o
);

  logic ds_cango;

  // only a load-use hazard holds the stage
  assign ds_cango      = !hazard_i;
  assign ds_allowin_o  = !ds_valid_o || (ds_cango && es_allowin_i);
  assign issue_valid_o = ds_valid_o && ds_cango;

  always_ff @(posedge clock) begin
    if (reset) begin
      ds_valid_o <= 1'b0;
    end else if (ds_allowin_o) begin
      ds_valid_o <= fs_valid_i && !flush_i;
    end
  end

  always_ff @(posedge clock) begin
    if (fs_valid_i && ds_allowin_o) begin
      ds_pc_o   <= fs_pc_i;
      ds_inst_o <= fs_inst_i;
    end
  end

  // a hazard is only reported for an instruction the stage holds
  hazard_needs_valid: assert property (
    @(posedge clock) disable iff (reset) hazard_i |-> ds_valid_o);

  // held instruction stays put until the stage opens again
  hold_when_blocked: assert property (
    @(posedge clock) disable iff (reset)
    ds_valid_o && !ds_allowin_o |=> ds_valid_o && $stable(ds_pc_o) && $stable(ds_inst_o));

endmodule

//--- logic/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve (
  input  logic                        ds_valid_i,
  input  decode_pkg::op_e             op_i,
  input  logic [decode_pkg::XLEN-1:0] ds_pc_i,
  input  logic [decode_pkg::XLEN-1:0] ds_inst_i,
  input  logic [decode_pkg::XLEN-1:0] v1_i,
  input  logic [decode_pkg::XLEN-1:0] v2_i,
  input  logic [decode_pkg::XLEN-1:0] v3_i,
  output logic                        br_taken_o,
  output logic [decode_pkg::XLEN-1:0] br_target_o
);
  import decode_pkg::*;

  logic [XLEN-1:0] pc_plus4;
  logic            equal;
  logic            taken;

  assign pc_plus4 = ds_pc_i + XLEN'(4);
  assign equal    = (v1_i == v2_i);

  always_comb begin
    case (op_i)
      op_beq:              taken = equal;
      op_bne:              taken = !equal;
      op_j, op_jal, op_jr: taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  assign br_taken_o = ds_valid_i & taken;

  always_comb begin
    case (op_i)
      op_beq, op_bne: br_target_o = pc_plus4 + v3_i;
      op_j, op_jal:   br_target_o = {pc_plus4[31:28], ds_inst_i[25:0], 2'b00};
      op_jr:          br_target_o = v3_i;
      // fall through for everything else
      default:        br_target_o = pc_plus4;
    endcase
  end

endmodule

//--- logic/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
  input  logic                        ds_valid_i,
  input  logic [decode_pkg::XLEN-1:0] ds_inst_i,
  input  decode_pkg::reg_addr_t       src1_reg_i,
  input  decode_pkg::reg_addr_t       src2_reg_i,
  input  logic                        src1_en_i,
  input  logic                        src2_en_i,
  input  decode_pkg::imm_kind_e       imm_kind_i,
  input  logic                        v3_from_rt_i,
  input  logic                        v3_from_rs_i,
  input  logic [decode_pkg::XLEN-1:0] rf_rdata0_i,
  input  logic [decode_pkg::XLEN-1:0] rf_rdata1_i,
  input  logic                        es_valid_i,
  input  logic                        es_load_i,
  input  logic                        es_wen_i,
  input  decode_pkg::reg_addr_t       es_waddr_i,
  input  logic [decode_pkg::XLEN-1:0] es_wdata_i,
  input  logic                        ms_valid_i,
  input  logic                        ms_wen_i,
  input  decode_pkg::reg_addr_t       ms_waddr_i,
  input  logic [decode_pkg::XLEN-1:0] ms_wdata_i,
  input  logic                        wb_we_i,
  input  decode_pkg::reg_addr_t       wb_waddr_i,
  input  logic [decode_pkg::XLEN-1:0] wb_wdata_i,
  output logic                        v1_en_o,
  output logic [decode_pkg::XLEN-1:0] v1_o,
  output logic                        v2_en_o,
  output logic [decode_pkg::XLEN-1:0] v2_o,
  output logic                        v3_en_o,
  output logic [decode_pkg::XLEN-1:0] v3_o,
  output logic                        hazard_o
);
  import decode_pkg::*;

  logic [15:0]     imm;
  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] val0;
  logic [XLEN-1:0] val1;
  logic            use0;
  logic            use1;
  logic            v3_reg;

  assign imm      = ds_inst_i[15:0];
  assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
  assign v3_reg   = v3_from_rt_i | v3_from_rs_i;
  assign use0     = src1_en_i;
  assign use1     = src2_en_i | v3_reg;

  function automatic logic load_hit(reg_addr_t src);
    return src != REG_ZERO && es_valid_i && es_wen_i && es_load_i && es_waddr_i == src;
  endfunction

  // execute, then memory, then writeback, then the array
  function automatic logic [XLEN-1:0] fwd_value(reg_addr_t src, logic [XLEN-1:0] rf_val);
    logic nonzero;
    nonzero = (src != REG_ZERO);
    if (nonzero && es_valid_i && es_wen_i && es_waddr_i == src) begin
      fwd_value = es_load_i ? '0 : es_wdata_i;
    end else if (nonzero && ms_valid_i && ms_wen_i && ms_waddr_i == src) begin
      fwd_value = ms_wdata_i;
    end else if (nonzero && wb_we_i && wb_waddr_i == src) begin
      fwd_value = wb_wdata_i;
    end else begin
      fwd_value = rf_val;
    end
  endfunction

  always_comb begin
    val0     = fwd_value(src1_reg_i, rf_rdata0_i);
    val1     = fwd_value(src2_reg_i, rf_rdata1_i);
    hazard_o = ds_valid_i && ((use0 && load_hit(src1_reg_i)) || (use1 && load_hit(src2_reg_i)));
  end

  assign v1_en_o = src1_en_i | (imm_kind_i == imm_upper);
  assign v1_o    = src1_en_i ? val0 :
                   (imm_kind_i == imm_upper) ? {imm, 16'h0000} : '0;

  always_comb begin
    v2_en_o = 1'b1;
    v2_o    = '0;
    if (src2_en_i) begin
      v2_o = val1;
    end else begin
      case (imm_kind_i)
        imm_sign:  v2_o = imm_sext;
        imm_zero:  v2_o = {16'h0000, imm};
        imm_shamt: v2_o = {27'd0, ds_inst_i[10:6]};
        default:   v2_en_o = 1'b0;
      endcase
    end
  end

  // branch offset is word aligned and the jump index stays unshifted
  assign v3_en_o = v3_reg | (imm_kind_i == imm_branch) | (imm_kind_i == imm_jump);
  assign v3_o    = v3_reg ? val1 :
                   (imm_kind_i == imm_branch) ? {imm_sext[XLEN-3:0], 2'b00} :
                   (imm_kind_i == imm_jump) ? {6'd0, ds_inst_i[25:0]} : '0;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
  parameter int REG_COUNT = 32
) (
  input  logic                        clock,
  input  decode_pkg::reg_addr_t       raddr0_i,
  input  decode_pkg::reg_addr_t       raddr1_i,
  input  logic                        we_i,
  input  decode_pkg::reg_addr_t       waddr_i,
  input  logic [decode_pkg::XLEN-1:0] wdata_i,
  output logic [decode_pkg::XLEN-1:0] rdata0_o,
  output logic [decode_pkg::XLEN-1:0] rdata1_o
);
  import decode_pkg::*;

  logic [XLEN-1:0] regs [REG_COUNT];

  // r0 and numbers past the array are not backed by storage
  function automatic logic backed(reg_addr_t addr);
    return addr != REG_ZERO && int'(addr) < REG_COUNT;
  endfunction

  always_comb begin
    rdata0_o = '0;
    rdata1_o = '0;
    if (backed(raddr0_i)) begin
      rdata0_o = regs[raddr0_i];
    end
    if (backed(raddr1_i)) begin
      rdata1_o = regs[raddr1_i];
    end
  end

  always_ff @(posedge clock) begin
    if (we_i && backed(waddr_i)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
  input  logic [decode_pkg::XLEN-1:0] ds_inst_i,
  output decode_pkg::op_e             op_o,
  output decode_pkg::reg_addr_t       src1_reg_o,
  output decode_pkg::reg_addr_t       src2_reg_o,
  output logic                        src1_en_o,
  output logic                        src2_en_o,
  output decode_pkg::imm_kind_e       imm_kind_o,
  output logic                        v3_from_rt_o,
  output logic                        v3_from_rs_o,
  output logic                        dest_en_o,
  output decode_pkg::reg_addr_t       dest_o
);
  import decode_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  reg_addr_t  rs;
  reg_addr_t  rt;
  reg_addr_t  rd;
  logic [4:0] sa;

  assign opcode = ds_inst_i[31:26];
  assign rs     = ds_inst_i[25:21];
  assign rt     = ds_inst_i[20:16];
  assign rd     = ds_inst_i[15:11];
  assign sa     = ds_inst_i[10:6];
  assign funct  = ds_inst_i[5:0];

  // opcode and function match
  always_comb begin
    op_o = op_nop;
    case (opcode)
      OPC_SPECIAL: begin
        if (sa == 5'd0) begin
          case (funct)
            FN_ADDU: op_o = op_addu;
            FN_SUBU: op_o = op_subu;
            FN_AND:  op_o = op_and;
            FN_OR:   op_o = op_or;
            FN_XOR:  op_o = op_xor;
            FN_NOR:  op_o = op_nor;
            FN_SLT:  op_o = op_slt;
            FN_SLTU: op_o = op_sltu;
            FN_JR: begin
              if (rt == REG_ZERO && rd == REG_ZERO) begin
                op_o = op_jr;
              end
            end
            default: ;
          endcase
        end
        // fixed shifts need rs clear
        if (rs == REG_ZERO) begin
          case (funct)
            FN_SLL:  op_o = op_sll;
            FN_SRL:  op_o = op_srl;
            FN_SRA:  op_o = op_sra;
            default: ;
          endcase
        end
      end
      OPC_ADDIU: op_o = op_addiu;
      OPC_SLTI:  op_o = op_slti;
      OPC_SLTIU: op_o = op_sltiu;
      OPC_ANDI:  op_o = op_andi;
      OPC_ORI:   op_o = op_ori;
      OPC_XORI:  op_o = op_xori;
      OPC_LUI:   op_o = (rs == REG_ZERO) ? op_lui : op_nop;
      OPC_LW:    op_o = op_lw;
      OPC_SW:    op_o = op_sw;
      OPC_BEQ:   op_o = op_beq;
      OPC_BNE:   op_o = op_bne;
      OPC_J:     op_o = op_j;
      OPC_JAL:   op_o = op_jal;
      default:   ;
    endcase
  end

  // operand sources and destination per operation
  always_comb begin
    src1_reg_o   = rs;
    src2_reg_o   = rt;
    src1_en_o    = 1'b0;
    src2_en_o    = 1'b0;
    imm_kind_o   = imm_none;
    v3_from_rt_o = 1'b0;
    v3_from_rs_o = 1'b0;
    dest_en_o    = 1'b0;
    dest_o       = REG_ZERO;
    case (op_o)
      op_addu, op_subu, op_and, op_or, op_xor, op_nor, op_slt, op_sltu: begin
        src1_en_o = 1'b1;
        src2_en_o = 1'b1;
        dest_en_o = 1'b1;
        dest_o    = rd;
      end
      op_sll, op_srl, op_sra: begin
        src1_reg_o = rt;
        src1_en_o  = 1'b1;
        imm_kind_o = imm_shamt;
        dest_en_o  = 1'b1;
        dest_o     = rd;
      end
      op_addiu, op_slti, op_sltiu, op_lw: begin
        src1_en_o  = 1'b1;
        imm_kind_o = imm_sign;
        dest_en_o  = 1'b1;
        dest_o     = rt;
      end
      op_andi, op_ori, op_xori: begin
        src1_en_o  = 1'b1;
        imm_kind_o = imm_zero;
        dest_en_o  = 1'b1;
        dest_o     = rt;
      end
      op_lui: begin
        imm_kind_o = imm_upper;
        dest_en_o  = 1'b1;
        dest_o     = rt;
      end
      op_sw: begin
        src1_en_o    = 1'b1;
        imm_kind_o   = imm_sign;
        v3_from_rt_o = 1'b1;
      end
      op_beq, op_bne: begin
        src1_en_o  = 1'b1;
        src2_en_o  = 1'b1;
        imm_kind_o = imm_branch;
      end
      op_j: imm_kind_o = imm_jump;
      op_jal: begin
        imm_kind_o = imm_jump;
        dest_en_o  = 1'b1;
        dest_o     = 5'd31;
      end
      op_jr: begin
        src2_reg_o   = rs;
        v3_from_rs_o = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- logic/decode_pkg.sv
package decode_pkg;

  parameter int XLEN = 32;

  typedef logic [4:0] reg_addr_t;

  localparam reg_addr_t REG_ZERO = 5'd0;

  // issued operation with one code per kept instruction
  typedef enum logic [4:0] {
    op_nop,
    op_addu,
    op_subu,
    op_and,
    op_or,
    op_xor,
    op_nor,
    op_slt,
    op_sltu,
    op_sll,
    op_srl,
    op_sra,
    op_addiu,
    op_andi,
    op_ori,
    op_xori,
    op_slti,
    op_sltiu,
    op_lui,
    op_lw,
    op_sw,
    op_beq,
    op_bne,
    op_j,
    op_jal,
    op_jr
  } op_e;

  typedef enum logic [2:0] {
    imm_none,
    imm_sign,
    imm_zero,
    imm_upper,
    imm_shamt,
    imm_branch,
    imm_jump
  } imm_kind_e;

  // primary opcodes
  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_J       = 6'h02;
  localparam logic [5:0] OPC_JAL     = 6'h03;
  localparam logic [5:0] OPC_BEQ     = 6'h04;
  localparam logic [5:0] OPC_BNE     = 6'h05;
  localparam logic [5:0] OPC_ADDIU   = 6'h09;
  localparam logic [5:0] OPC_SLTI    = 6'h0a;
  localparam logic [5:0] OPC_SLTIU   = 6'h0b;
  localparam logic [5:0] OPC_ANDI    = 6'h0c;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_XORI    = 6'h0e;
  localparam logic [5:0] OPC_LUI     = 6'h0f;
  localparam logic [5:0] OPC_LW      = 6'h23;
  localparam logic [5:0] OPC_SW      = 6'h2b;

  // special function codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SRA  = 6'h03;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage
